// File: elinkLoop.f
+incdir+common
common/elinkPkg.sv
encoder/enc8b10b.sv
encoder/elinkTx.sv
decoder/dec8b10b.sv
decoder/elinkRx.sv
rtl/elinkFifo.sv
rtl/elinkLoopTop.sv
sim/tbElinkLoop.sv

// File: Makefile
VERILATOR ?= verilator
SIMFLAGS  ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tbElinkLoop
FILELIST  ?= elinkLoop.f
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the simulation prints the pass line
sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJDIR)

// File: sim/tbElinkLoop.sv
// Directed testbench for the E-link loopback transceiver
// Plays the word source, closes the lane loop with an error injection mask
// and checks the receive FIFO against a queue of expected entries
`default_nettype none
`timescale 1ns/1ps
`include "elink_consts.svh"

module tbElinkLoop;

  logic                 getDataTrig = 1'b0;
  logic                 rst = 1'b1;
  logic                 wordReq;
  logic                 wordValid = 1'b0;
  elinkPkg::elinkWord_t wordIn = '0;
  logic [1:0]           laneOut;
  logic [1:0]           laneIn;
  logic [1:0]           laneMask = 2'b00; // Bit flips on the loopback
  logic                 rdEn = 1'b0;
  elinkPkg::rxEntry_t   dout;
  logic                 empty;
  logic                 full;
  logic                 overflow;
  logic                 locked;

  elinkPkg::elinkWord_t srcQ [$]; // Words waiting for a request slot
  int                   gapQ [$]; // Empty slots before each word
  elinkPkg::rxEntry_t   expQ [$]; // Reference model of the FIFO contents
  bit                   reqSeen = 1'b0;
  integer               seed;
  int                   errorCount = 0;
  int                   checksDone = 0;
  int                   cycleCount = 0;
  int                   cycleLimit = 400;

  elinkLoopTop elinkLoopTop_i (
    .getDataTrig (getDataTrig),
    .rst         (rst),
    .wordReq     (wordReq),
    .wordValid   (wordValid),
    .wordIn      (wordIn),
    .laneOut     (laneOut),
    .laneIn      (laneIn),
    .rdEn        (rdEn),
    .dout        (dout),
    .empty       (empty),
    .full        (full),
    .overflow    (overflow),
    .locked      (locked)
  );

  assign laneIn = laneOut ^ laneMask; // External loopback

  always #5 getDataTrig = ~getDataTrig;

  // Source, answers in the cycle after wordReq
  always @(negedge getDataTrig)
  begin
    wordValid = 1'b0;
    if (reqSeen && srcQ.size() > 0)
    begin
      if (gapQ[0] > 0)
        gapQ[0] = gapQ[0] - 1;  // Slot left empty, TX sends a comma
      else
      begin
        wordIn = srcQ.pop_front();
        void'(gapQ.pop_front());
        wordValid = 1'b1;
      end
    end
    reqSeen = wordReq;
  end

  // Watchdog
  always @(posedge getDataTrig)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit)
    begin
      $display("Timeout: the run went past its limit of %0d cycles", cycleLimit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic elinkPkg::elinkWord_t makeWord(input elinkPkg::elinkDelim_t d,
                                                    input logic [7:0] p);
    elinkPkg::elinkWord_t w;
    w.delim   = d;
    w.payload = p;
    return w;
  endfunction

  // Expected FIFO entry, SOP and EOP return their K-code byte
  function automatic elinkPkg::rxEntry_t expectedEntry(input elinkPkg::elinkWord_t w);
    elinkPkg::rxEntry_t e;
    e.word    = w;
    e.codeErr = 1'b0;
    if (w.delim == elinkPkg::dSop)
      e.word.payload = `ELINK_K_SOP;
    else if (w.delim == elinkPkg::dEop)
      e.word.payload = `ELINK_K_EOP;
    return e;
  endfunction

  task automatic checkEntry(input elinkPkg::rxEntry_t got, input elinkPkg::rxEntry_t exp,
                            input string what);
    checksDone++;
    if (got !== exp)
    begin
      $display("Error at %0t: %s got %s %h err %b, expected %s %h err %b", $time, what,
               got.word.delim.name(), got.word.payload, got.codeErr,
               exp.word.delim.name(), exp.word.payload, exp.codeErr);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string name);
    checksDone++;
    if (got !== exp)
    begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkCount(input int got, input int exp, input string name);
    checksDone++;
    if (got != exp)
    begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic sendWord(input elinkPkg::elinkWord_t w, input int gaps, input bit track);
    srcQ.push_back(w);
    gapQ.push_back(gaps);
    if (track && w.delim != elinkPkg::dIdle)
      expQ.push_back(expectedEntry(w));
    cycleLimit += `ELINK_WORD_CYCLES * (gaps + 1);
  endtask

  // Pops the head entry once empty drops, gives up after bound cycles
  task automatic popEntry(output elinkPkg::rxEntry_t e, output bit ok, input int bound);
    int waited;
    waited = 0;
    ok     = 1'b0;
    e      = '0;
    while (!ok && waited < bound)
    begin
      if (!empty)
      begin
        e    = dout;
        rdEn = 1'b1;
        ok   = 1'b1;
      end
      @(negedge getDataTrig);
      rdEn = 1'b0;
      waited++;
    end
  endtask

  task automatic drainExpected(output int n);
    elinkPkg::rxEntry_t got;
    bit                 ok;
    n = 0;
    cycleLimit += 6 * `ELINK_WORD_CYCLES; // Source to FIFO latency
    while (expQ.size() > 0)
    begin
      popEntry(got, ok, 12 * `ELINK_WORD_CYCLES);
      if (!ok)
      begin
        $display("No FIFO entry arrived in time, %0d entries still expected", expQ.size());
        errorCount++;
        expQ.delete();
      end
      else
      begin
        checkEntry(got, expQ.pop_front(), "FIFO entry");
        n++;
      end
    end
  endtask

  task automatic checkQuiet(input int cycles);
    bit sawEntry;
    sawEntry = 1'b0;
    cycleLimit += cycles;
    repeat (cycles)
    begin
      @(negedge getDataTrig);
      if (!empty)
        sawEntry = 1'b1;
    end
    checkFlag(sawEntry, 1'b0, "unexpected FIFO entry");
  endtask

  // Idle lane carries K28.5 in both polarities, bit a first, one request per word
  task automatic checkIdleLane();
    logic [39:0] bits;
    logic [19:0] commaPair;
    int          reqs;
    bit          found;
    commaPair = {10'b1010000011, 10'b0101111100}; // RD- comma then RD+ comma
    reqs      = 0;
    found     = 1'b0;
    cycleLimit += 20;
    for (int i = 0; i < 20; i++)
    begin
      @(negedge getDataTrig);
      bits[2*i +: 2] = laneOut;
      if (wordReq)
        reqs++;
    end
    for (int o = 0; o <= 20; o += 2)
      if (bits[o +: 20] == commaPair)
        found = 1'b1;
    checkFlag(found, 1'b1, "comma pattern on laneOut");
    checkCount(reqs, 4, "wordReq strobes in 20 cycles");
  endtask

  // One-cycle flip of the middle bit pair of word w on the lane
  task automatic flipLanePair(input elinkPkg::elinkWord_t w);
    int waited;
    waited = 0;
    @(posedge getDataTrig);
    while (!(wordValid && wordIn == w) && waited < 100)
    begin
      @(posedge getDataTrig);
      waited++;
    end
    if (waited >= 100)
    begin
      $display("The word chosen for bit flips was never sent");
      errorCount++;
    end
    else
    begin
      repeat (6) @(negedge getDataTrig); // Load after 3, third pair 2 later
      laneMask = 2'b11;
      @(negedge getDataTrig);
      laneMask = 2'b00;
    end
  endtask

  task automatic lockOnIdle();
    int waited;
    waited = 0;
    cycleLimit += 40;
    while (!locked && waited < 40)
    begin
      @(negedge getDataTrig);
      waited++;
    end
    checkFlag(locked, 1'b1, "locked 40 cycles after reset");
    checkIdleLane();
    checkQuiet(100); // Commas only
  endtask

  task automatic packetRoundTrip();
    int n;
    sendWord(makeWord(elinkPkg::dSop, 8'h00), 0, 1'b1);
    sendWord(makeWord(elinkPkg::dData, 8'h11), 0, 1'b1);
    sendWord(makeWord(elinkPkg::dData, 8'h22), 0, 1'b1);
    sendWord(makeWord(elinkPkg::dData, 8'h33), 0, 1'b1);
    sendWord(makeWord(elinkPkg::dEop, 8'h00), 0, 1'b1);
    drainExpected(n);
    checkCount(n, 5, "packet entries");
  endtask

  task automatic allByteValues();
    int n;
    int total;
    total = 0;
    for (int b = 0; b < 256; b += 12)
    begin
      for (int i = b; i < b + 12 && i < 256; i++)
        sendWord(makeWord(elinkPkg::dData, 8'(i)), 0, 1'b1);
      drainExpected(n);
      total += n;
    end
    checkCount(total, 256, "byte entries");
  endtask

  task automatic dataGaps();
    logic [31:0] r;
    int          gap;
    int          n;
    for (int i = 0; i < 24; i++)
    begin
      r   = $random(seed);
      gap = int'(r[1:0]); // Zero to three empty slots
      r   = $random(seed);
      sendWord(makeWord(elinkPkg::dData, r[7:0]), gap, 1'b1);
    end
    drainExpected(n);
    checkCount(n, 24, "entries with gaps");
    checkQuiet(30);
  endtask

  task automatic laneCorruption();
    elinkPkg::elinkWord_t pre0;
    elinkPkg::elinkWord_t pre1;
    elinkPkg::elinkWord_t hitWord;
    elinkPkg::elinkWord_t post0;
    elinkPkg::elinkWord_t post1;
    elinkPkg::rxEntry_t   got [$];
    elinkPkg::rxEntry_t   e;
    bit                   ok;
    bit                   hit;
    pre0    = makeWord(elinkPkg::dData, 8'h5A);
    pre1    = makeWord(elinkPkg::dData, 8'hA5);
    hitWord = makeWord(elinkPkg::dData, 8'h00);
    post0   = makeWord(elinkPkg::dData, 8'h3C);
    post1   = makeWord(elinkPkg::dData, 8'hC3);
    sendWord(pre0, 0, 1'b0);
    sendWord(pre1, 0, 1'b0);
    sendWord(hitWord, 0, 1'b0);
    sendWord(post0, 2, 1'b0); // Commas restore the disparity
    sendWord(post1, 0, 1'b0);
    flipLanePair(hitWord);
    cycleLimit += 100;
    ok = 1'b1;
    while (ok)
    begin
      popEntry(e, ok, 40);
      if (ok)
        got.push_back(e);
    end
    if (got.size() < 4)
    begin
      $display("Only %0d entries came back after the bit flip", got.size());
      errorCount++;
    end
    else
    begin
      checkEntry(got[0], expectedEntry(pre0), "entry before flip");
      checkEntry(got[1], expectedEntry(pre1), "entry before flip");
      checkEntry(got[got.size()-2], expectedEntry(post0), "entry after flip");
      checkEntry(got[got.size()-1], expectedEntry(post1), "entry after flip");
      hit = 1'b0;
      for (int i = 2; i < got.size() - 2; i++)
        if (got[i].codeErr || got[i].word != hitWord)
          hit = 1'b1;
      checkFlag(hit, 1'b1, "corrupted word flagged");
    end
  endtask

  task automatic fifoOverflow();
    int waited;
    int n;
    waited = 0;
    for (int i = 0; i < 20; i++)
      sendWord(makeWord(elinkPkg::dData, 8'(8'hC0 + i)), 0, i < `ELINK_FIFO_DEPTH);
    while (srcQ.size() > 0 && waited < 200)
    begin
      @(negedge getDataTrig);
      waited++;
    end
    cycleLimit += 30;
    repeat (30) @(negedge getDataTrig); // Last word into the FIFO
    checkFlag(full, 1'b1, "full");
    checkFlag(overflow, 1'b1, "overflow");
    drainExpected(n);
    checkCount(n, `ELINK_FIFO_DEPTH, "entries kept on overflow");
    checkFlag(empty, 1'b1, "empty after drain");
    checkQuiet(20);
    checkFlag(overflow, 1'b1, "overflow held");
  endtask

  initial
  begin
    seed = 32'h344cb722;
    cycleLimit += 16;
    repeat (16) @(negedge getDataTrig);
    rst = 1'b0;
    checkFlag(wordReq, 1'b0, "wordReq after reset");
    checkFlag(locked, 1'b0, "locked after reset");
    checkFlag(empty, 1'b1, "empty after reset");
    checkFlag(full, 1'b0, "full after reset");
    checkFlag(overflow, 1'b0, "overflow after reset");
    lockOnIdle();
    packetRoundTrip();
    allByteValues();
    dataGaps();
    laneCorruption();
    fifoOverflow();
    $display("Checks: %0d, errors: %0d", checksDone, errorCount);
    if (errorCount == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/elinkLoopTop.sv
// Top level of the E-link transceiver
// Transmit path drives laneOut, receive path samples laneIn into the FIFO
// The loopback wire from laneOut to laneIn sits outside this module
`default_nettype none
`timescale 1ns/1ps

module elinkLoopTop (
  input  logic                 getDataTrig,
  input  logic                 rst,
  output logic                 wordReq,
  input  logic                 wordValid,
  input  elinkPkg::elinkWord_t wordIn,
  output logic [1:0]           laneOut,
  input  logic [1:0]           laneIn,
  input  logic                 rdEn,
  output elinkPkg::rxEntry_t   dout,
  output logic                 empty,
  output logic                 full,
  output logic                 overflow,
  output logic                 locked
);

  logic               rxWrEn; // Receive entry strobe
  elinkPkg::rxEntry_t rxEntry;

  elinkTx tx_i (
    .getDataTrig (getDataTrig),
    .rst         (rst),
    .wordReq     (wordReq),
    .wordValid   (wordValid),
    .wordIn      (wordIn),
    .laneOut     (laneOut)
  );

  elinkRx rx_i (
    .getDataTrig (getDataTrig),
    .rst         (rst),
    .laneIn      (laneIn),
    .wrEn        (rxWrEn),
    .entryOut    (rxEntry),
    .locked      (locked)
  );

  elinkFifo fifo_i (
    .getDataTrig (getDataTrig),
    .rst         (rst),
    .wrEn        (rxWrEn),
    .din         (rxEntry),
    .rdEn        (rdEn),
    .dout        (dout),
    .empty       (empty),
    .full        (full),
    .overflow    (overflow)
  );

endmodule

`default_nettype wire

// File: rtl/elinkFifo.sv
// First-word-fall-through FIFO of receive entries
// dout shows the head while empty is low, rdEn pops it
// A write into a full FIFO is dropped and sets the sticky overflow flag
`default_nettype none
`timescale 1ns/1ps
`include "elink_consts.svh"

module elinkFifo #(
  parameter int DEPTH = `ELINK_FIFO_DEPTH // Power of two
) (
  input  logic               getDataTrig,
  input  logic               rst,
  input  logic               wrEn,
  input  elinkPkg::rxEntry_t din,
  input  logic               rdEn,
  output elinkPkg::rxEntry_t dout,
  output logic               empty,
  output logic               full,
  output logic               overflow
);

  localparam int ptrW = $clog2(DEPTH);

  elinkPkg::rxEntry_t mem [DEPTH];
  logic [ptrW-1:0]    wrPtr;
  logic [ptrW-1:0]    rdPtr;
  logic [ptrW:0]      count; // One bit wider than the pointers
  logic               doWr;
  logic               doRd;

  assign empty = (count == '0);
  assign full  = (count == (ptrW + 1)'(DEPTH));
  assign doWr  = wrEn && !full;
  assign doRd  = rdEn && !empty;
  assign dout  = mem[rdPtr];

  always_ff @(posedge getDataTrig)
  begin
    if (doWr)
      mem[wrPtr] <= din;
  end

  always_ff @(posedge getDataTrig)
  begin
    if (rst)
    begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (doWr)
        wrPtr <= wrPtr + ptrW'(1);
      if (doRd)
        rdPtr <= rdPtr + ptrW'(1);
      if (doWr && !doRd)
        count <= count + (ptrW + 1)'(1);
      else if (doRd && !doWr)
        count <= count - (ptrW + 1)'(1);
      if (wrEn && full)
        overflow <= 1'b1;  // Held until reset
    end
  end

  assert property (@(posedge getDataTrig) disable iff (rst) rdEn |-> !empty);
  assert property (@(posedge getDataTrig) disable iff (rst) count <= (ptrW + 1)'(DEPTH));

endmodule

`default_nettype wire

// File: decoder/elinkRx.sv
// E-link receiver for the 2-bit lane
// Aligns on the K28.5 comma, then decodes one symbol every five clocks
// and writes non-idle words with an error bit to the receive FIFO
`default_nettype none
`timescale 1ns/1ps
`include "elink_consts.svh"

module elinkRx (
  input  logic               getDataTrig,
  input  logic               rst,
  input  logic [1:0]         laneIn,
  output logic               wrEn,
  output elinkPkg::rxEntry_t entryOut,
  output logic               locked
);

  localparam logic [2:0] lastPhase = 3'(`ELINK_WORD_CYCLES - 1);

  logic [9:0]         hist;  // Last ten bits, oldest at bit 0
  logic [2:0]         phase; // Full symbol in hist at 0
  logic               rdReg;
  logic [7:0]         decData;
  logic               decIsK;
  logic               decRd;
  logic               decErr;
  logic               isComma;
  logic               keep;  // Word goes to the FIFO
  elinkPkg::rxEntry_t entryNext;

  dec8b10b dec_i (
    .symIn   (hist),
    .rdIn    (rdReg),
    .dataOut (decData),
    .isK     (decIsK),
    .rdOut   (decRd),
    .codeErr (decErr)
  );

  // Either polarity decodes to K28.5
  assign isComma = decIsK && (decData == `ELINK_K_COMMA);

  // Character back to delimiter
  always_comb
  begin
    entryNext.word.delim   = elinkPkg::dData;
    entryNext.word.payload = decData;
    entryNext.codeErr      = decErr;
    keep                   = 1'b1;
    if (!decErr && decIsK)
    begin
      if (decData == `ELINK_K_SOP)
        entryNext.word.delim = elinkPkg::dSop;
      else if (decData == `ELINK_K_EOP)
        entryNext.word.delim = elinkPkg::dEop;
      else if (isComma)
      begin
        entryNext.word.delim = elinkPkg::dIdle;
        keep                 = 1'b0;       // Idles never stored
      end
      else
        entryNext.codeErr = 1'b1;          // K-code not used on this link
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    hist     <= {laneIn, hist[9:2]};        // Newest pair on top
    entryOut <= entryNext;
    if (rst)
    begin
      phase  <= 3'd0;
      locked <= 1'b0;
      rdReg  <= 1'b0;
      wrEn   <= 1'b0;
    end
    else
    begin
      wrEn <= 1'b0;
      if (!locked)
      begin
        if (isComma)
        begin
          locked <= 1'b1;
          phase  <= 3'd1;                   // Next symbol five clocks on
          rdReg  <= decRd;                  // K28.5 fixes the disparity
        end
      end
      else
      begin
        phase <= (phase == lastPhase) ? 3'd0 : phase + 3'd1;
        if (phase == 3'd0)
        begin
          rdReg <= decRd;
          wrEn  <= keep;
        end
      end
    end
  end

  assert property (@(posedge getDataTrig) disable iff (rst) wrEn |-> locked);

endmodule

`default_nettype wire

// File: decoder/dec8b10b.sv
// Combinational 8b10b decoder
// Flags unknown 6b or 4b sub-blocks and breaks of the disparity rule
// symIn bit 0 is code bit a, the first bit on the wire
`default_nettype none
`timescale 1ns/1ps

module dec8b10b (
  input  logic [9:0] symIn,
  input  logic       rdIn,    // 0 = RD-, 1 = RD+
  output logic [7:0] dataOut, // HGF_EDCBA
  output logic       isK,
  output logic       rdOut,
  output logic       codeErr
);

  logic [9:0] code;    // abcdei fghj, a in msb
  logic [5:0] six;
  logic [3:0] four;
  logic [3:0] fourAdj;
  logic [4:0] x;
  logic [2:0] y;
  logic       bad6;
  logic       bad4;
  logic       isA7;
  logic       k28;
  logic       rd6;
  logic       dispErr;

  assign code = {<<{symIn}};
  assign six  = code[9:4];
  assign four = code[3:0];
  assign k28  = (six == 6'b001111) || (six == 6'b110000);

  // Reverse 5b/6b, both polarities
  always_comb
  begin
    bad6 = 1'b0;
    case (six)
      6'b100111, 6'b011000: x = 5'd0;
      6'b011101, 6'b100010: x = 5'd1;
      6'b101101, 6'b010010: x = 5'd2;
      6'b110001:            x = 5'd3;
      6'b110101, 6'b001010: x = 5'd4;
      6'b101001:            x = 5'd5;
      6'b011001:            x = 5'd6;
      6'b111000, 6'b000111: x = 5'd7;
      6'b111001, 6'b000110: x = 5'd8;
      6'b100101:            x = 5'd9;
      6'b010101:            x = 5'd10;
      6'b110100:            x = 5'd11;
      6'b001101:            x = 5'd12;
      6'b101100:            x = 5'd13;
      6'b011100:            x = 5'd14;
      6'b010111, 6'b101000: x = 5'd15;
      6'b011011, 6'b100100: x = 5'd16;
      6'b100011:            x = 5'd17;
      6'b010011:            x = 5'd18;
      6'b110010:            x = 5'd19;
      6'b001011:            x = 5'd20;
      6'b101010:            x = 5'd21;
      6'b011010:            x = 5'd22;
      6'b111010, 6'b000101: x = 5'd23;
      6'b110011, 6'b001100: x = 5'd24;
      6'b100110:            x = 5'd25;
      6'b010110:            x = 5'd26;
      6'b110110, 6'b001001: x = 5'd27;
      6'b001110, 6'b001111, 6'b110000: x = 5'd28; // D28 and K28
      6'b101110, 6'b010001: x = 5'd29;
      6'b011110, 6'b100001: x = 5'd30;
      6'b101011, 6'b010100: x = 5'd31;
      default:
      begin
        x    = 5'd0;
        bad6 = 1'b1;
      end
    endcase
  end

  // K28 after 110000 carries inverted balanced 4b forms
  assign fourAdj = (six == 6'b110000 && $countones(four) == 2 &&
                    four != 4'b0011 && four != 4'b1100) ? ~four : four;

  always_comb
  begin
    bad4 = 1'b0;
    isA7 = 1'b0;
    case (fourAdj)
      4'b1011, 4'b0100: y = 3'd0;
      4'b1001:          y = 3'd1;
      4'b0101:          y = 3'd2;
      4'b1100, 4'b0011: y = 3'd3;
      4'b1101, 4'b0010: y = 3'd4;
      4'b1010:          y = 3'd5;
      4'b0110:          y = 3'd6;
      4'b1110, 4'b0001: y = 3'd7;
      4'b0111, 4'b1000:
      begin
        y    = 3'd7;
        isA7 = 1'b1;
      end
      default:
      begin
        y    = 3'd0;
        bad4 = 1'b1; // 0000 or 1111
      end
    endcase
  end

  // Heavy blocks need RD- before them, light blocks RD+
  assign rd6 = ($countones(six) == 3) ? rdIn : ($countones(six) == 4);
  assign dispErr = (($countones(six) == 4 || six == 6'b111000) && rdIn) ||
                   (($countones(six) == 2 || six == 6'b000111) && !rdIn) ||
                   (($countones(four) == 3 || four == 4'b1100) && rd6) ||
                   (($countones(four) == 1 || four == 4'b0011) && !rd6);
  assign rdOut   = ($countones(four) == 2) ? rd6 : ($countones(four) == 3);

  assign isK     = k28 || (isA7 && (x == 5'd23 || x == 5'd27 || x == 5'd29 || x == 5'd30));
  assign dataOut = {y, x};
  assign codeErr = bad6 || bad4 || dispErr;

endmodule

`default_nettype wire

// File: encoder/elinkTx.sv
// E-link transmitter, one 8b10b symbol every five clocks on a 2-bit lane
// Requests a word from the source, maps its delimiter to a character,
// encodes it and shifts it out lsb pair first
`default_nettype none
`timescale 1ns/1ps
`include "elink_consts.svh"

module elinkTx (
  input  logic                 getDataTrig,
  input  logic                 rst,
  output logic                 wordReq,
  input  logic                 wordValid,
  input  elinkPkg::elinkWord_t wordIn,
  output logic [1:0]           laneOut
);

  localparam logic [2:0] lastPhase = 3'(`ELINK_WORD_CYCLES - 1);

  logic [2:0] phase;    // wordReq at 1, response at 2, load at 0
  logic [7:0] charNext;
  logic       isKNext;
  logic [7:0] charReg;  // Character waiting for the next load
  logic       isKReg;
  logic       rdReg;    // Running disparity of the sent stream
  logic       rdNext;
  logic [9:0] symbol;
  logic [9:0] shiftReg;

  // Delimiter to character, missing word becomes idle
  always_comb
  begin
    charNext = `ELINK_K_COMMA;
    isKNext  = 1'b1;
    if (wordValid)
    begin
      case (wordIn.delim)
        elinkPkg::dData:
        begin
          charNext = wordIn.payload;
          isKNext  = 1'b0;
        end
        elinkPkg::dSop: charNext = `ELINK_K_SOP;
        elinkPkg::dEop: charNext = `ELINK_K_EOP;
        default:        charNext = `ELINK_K_COMMA;
      endcase
    end
  end

  enc8b10b enc_i (
    .dataIn (charReg),
    .isK    (isKReg),
    .rdIn   (rdReg),
    .symOut (symbol),
    .rdOut  (rdNext)
  );

  always_ff @(posedge getDataTrig)
  begin
    if (rst)
    begin
      phase    <= 3'd0;
      wordReq  <= 1'b0;
      charReg  <= `ELINK_K_COMMA; // First slot is a comma
      isKReg   <= 1'b1;
      rdReg    <= 1'b0;
      shiftReg <= 10'd0;
    end
    else
    begin
      phase   <= (phase == lastPhase) ? 3'd0 : phase + 3'd1;
      wordReq <= (phase == 3'd0);
      if (phase == 3'd2) // Source response cycle
      begin
        charReg <= charNext;
        isKReg  <= isKNext;
      end
      if (phase == 3'd0)
      begin
        shiftReg <= symbol; // On the lane from phase 1
        rdReg    <= rdNext;
      end
      else
        shiftReg <= {2'b00, shiftReg[9:2]};
    end
  end

  assign laneOut = shiftReg[1:0];

  // One-cycle request strobe
  assert property (@(posedge getDataTrig) disable iff (rst) wordReq |=> !wordReq);

endmodule

`default_nettype wire

// File: encoder/enc8b10b.sv
// Combinational 8b10b encoder for D and K characters
// Running disparity goes in and out, the caller keeps the register
// symOut bit 0 is code bit a, the first bit on the wire
`default_nettype none
`timescale 1ns/1ps

module enc8b10b (
  input  logic [7:0] dataIn,
  input  logic       isK,
  input  logic       rdIn,  // 0 = RD-, 1 = RD+
  output logic [9:0] symOut,
  output logic       rdOut
);

  logic [4:0] x;       // EDCBA
  logic [2:0] y;       // HGF
  logic       k28;
  logic [5:0] sixTbl;  // abcdei, RD- form, a in msb
  logic [5:0] six;
  logic       rd6;     // Disparity after the 6b block
  logic       useA7;
  logic [3:0] fourTbl; // fghj, RD- form
  logic [3:0] four;
  logic [9:0] code;    // abcdei fghj, a in msb

  assign x   = dataIn[4:0];
  assign y   = dataIn[7:5];
  assign k28 = isK && (x == 5'd28);

  // 5b/6b table, RD- column
  always_comb
  begin
    case (x)
      5'd0:    sixTbl = 6'b100111;
      5'd1:    sixTbl = 6'b011101;
      5'd2:    sixTbl = 6'b101101;
      5'd3:    sixTbl = 6'b110001;
      5'd4:    sixTbl = 6'b110101;
      5'd5:    sixTbl = 6'b101001;
      5'd6:    sixTbl = 6'b011001;
      5'd7:    sixTbl = 6'b111000;
      5'd8:    sixTbl = 6'b111001;
      5'd9:    sixTbl = 6'b100101;
      5'd10:   sixTbl = 6'b010101;
      5'd11:   sixTbl = 6'b110100;
      5'd12:   sixTbl = 6'b001101;
      5'd13:   sixTbl = 6'b101100;
      5'd14:   sixTbl = 6'b011100;
      5'd15:   sixTbl = 6'b010111;
      5'd16:   sixTbl = 6'b011011;
      5'd17:   sixTbl = 6'b100011;
      5'd18:   sixTbl = 6'b010011;
      5'd19:   sixTbl = 6'b110010;
      5'd20:   sixTbl = 6'b001011;
      5'd21:   sixTbl = 6'b101010;
      5'd22:   sixTbl = 6'b011010;
      5'd23:   sixTbl = 6'b111010;
      5'd24:   sixTbl = 6'b110011;
      5'd25:   sixTbl = 6'b100110;
      5'd26:   sixTbl = 6'b010110;
      5'd27:   sixTbl = 6'b110110;
      5'd28:   sixTbl = k28 ? 6'b001111 : 6'b001110; // K28 has its own block
      5'd29:   sixTbl = 6'b101110;
      5'd30:   sixTbl = 6'b011110;
      default: sixTbl = 6'b101011;                    // x = 31
    endcase
  end

  // Unbalanced blocks and D.7 flip under RD+
  assign six = (rdIn && (($countones(sixTbl) != 3) || (x == 5'd7))) ? ~sixTbl : sixTbl;
  assign rd6 = rdIn ^ ($countones(six) != 3);

  // Alternate y=7 form, avoids a run of five equal bits
  assign useA7 = (y == 3'd7) &&
                 (isK || (!rd6 && ((x == 5'd17) || (x == 5'd18) || (x == 5'd20))) ||
                  (rd6 && ((x == 5'd11) || (x == 5'd13) || (x == 5'd14))));

  // 3b/4b table, RD- column
  always_comb
  begin
    case (y)
      3'd0:    fourTbl = 4'b1011;
      3'd1:    fourTbl = 4'b1001;
      3'd2:    fourTbl = 4'b0101;
      3'd3:    fourTbl = 4'b1100;
      3'd4:    fourTbl = 4'b1101;
      3'd5:    fourTbl = 4'b1010;
      3'd6:    fourTbl = 4'b0110;
      default: fourTbl = useA7 ? 4'b0111 : 4'b1110;
    endcase
    if (($countones(fourTbl) != 2) || (y == 3'd3))
      four = rd6 ? ~fourTbl : fourTbl; // Chosen by disparity
    else if (k28)
      four = rd6 ? fourTbl : ~fourTbl; // K28 inverts balanced forms after 110000
    else
      four = fourTbl;
  end

  assign rdOut  = rd6 ^ ($countones(four) != 2);
  assign code   = {six, four};
  assign symOut = {<<{code}}; // Bit a to lsb

endmodule

`default_nettype wire

// File: common/elinkPkg.sv
// Shared types of the E-link loopback transceiver
// Referenced by scoped name from the transmit, receive and FIFO blocks
`default_nettype none

package elinkPkg;

  // Word delimiter, carried in the top two bits of a link word
  typedef enum logic [1:0] {
    dData = 2'b00, // Payload is a data byte
    dEop  = 2'b01, // End of packet
    dSop  = 2'b10, // Start of packet
    dIdle = 2'b11  // Idle slot, sent as comma
  } elinkDelim_t;

  // Unit offered by the source and returned by the receive FIFO
  typedef struct packed {
    elinkDelim_t delim;
    logic [7:0]  payload; // Data byte, or K-code byte for SOP/EOP
  } elinkWord_t;

  // One receive FIFO entry
  typedef struct packed {
    elinkWord_t word;
    logic       codeErr; // Invalid symbol or disparity violation
  } rxEntry_t;

endpackage

`default_nettype wire

// File: common/elink_consts.svh
// Link constants for the E-link loopback transceiver
// Include wherever K-codes, the word period or the FIFO depth are needed
`ifndef ELINK_CONSTS_SVH
`define ELINK_CONSTS_SVH

// K-characters, HGF_EDCBA byte form
`define ELINK_K_COMMA 8'hBC // K28.5, idle and alignment
`define ELINK_K_SOP   8'h3C // K28.1
`define ELINK_K_EOP   8'hDC // K28.6

// Clocks per 10-bit symbol on the 2-bit lane
`define ELINK_WORD_CYCLES 5

// Default receive FIFO depth, power of two
`define ELINK_FIFO_DEPTH 16

`endif
